/* flist.f */
+incdir+tests
hdl/paillier_pkg.sv
hdl/mod_op_if.sv
hdl/mod_mul.sv
hdl/mod_exp.sv
hdl/operand_loader.sv
hdl/result_streamer.sv
hdl/paillier_ctrl.sv
hdl/paillier_top.sv
tests/tb_paillier_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_paillier_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/paillier_model.svh */
`ifndef PAILLIER_MODEL_SVH
`define PAILLIER_MODEL_SVH

// Modular product with a full double-width intermediate
function automatic paillier_pkg::operand_t mul_mod_ref(input paillier_pkg::operand_t x,
                                                       input paillier_pkg::operand_t y);
    logic [127:0] wide;
    wide = {64'd0, x} * {64'd0, y};
    return paillier_pkg::operand_t'(wide % {64'd0, paillier_pkg::paillier_nsq});
endfunction

// Right-to-left binary powering, x^0 gives one
function automatic paillier_pkg::operand_t exp_mod_ref(input paillier_pkg::operand_t x,
                                                       input paillier_pkg::operand_t k);
    paillier_pkg::operand_t acc;
    paillier_pkg::operand_t sq;
    acc = paillier_pkg::operand_t'(1);
    sq  = x;
    for (int i = 0; i < paillier_pkg::operand_w; i++) begin
        if (k[i]) begin
            acc = mul_mod_ref(acc, sq);
        end
        sq = mul_mod_ref(sq, sq);
    end
    return acc;
endfunction

// Ciphertext (1 + m*n) * r^n mod n^2
function automatic paillier_pkg::operand_t encrypt_ref(input paillier_pkg::operand_t m,
                                                       input paillier_pkg::operand_t r);
    paillier_pkg::operand_t n_ext;
    paillier_pkg::operand_t g;
    n_ext = paillier_pkg::operand_t'(paillier_pkg::paillier_n);
    g     = mul_mod_ref(m, n_ext) + paillier_pkg::operand_t'(1);
    return mul_mod_ref(g, exp_mod_ref(r, n_ext));
endfunction

`endif

/* tests/tb_paillier_top.sv */
module tb_paillier_top;
    timeunit 1ns;
    timeprecision 1ps;

    `include "paillier_model.svh"

    localparam int word_w      = 16;
    localparam int n_words     = paillier_pkg::operand_w / word_w;
    localparam int n_tests     = 10;
    localparam int out_timeout = 20000;
    // Outlasts the slowest task latency
    localparam int quiet_wait  = out_timeout;

    typedef struct {
        paillier_pkg::task_cmd_e cmd;
        paillier_pkg::operand_t  a;
        paillier_pkg::operand_t  b;
        int                      a_gap;
        int                      b_gap;
        bit                      rand_ops;
    } entry_t;

    logic                    clk;
    logic                    rst_n;
    logic                    task_req;
    paillier_pkg::task_cmd_e task_cmd;
    logic [word_w-1:0]       a_data;
    logic                    a_valid;
    logic [word_w-1:0]       b_data;
    logic                    b_valid;
    logic [word_w-1:0]       out_data;
    logic                    out_valid;
    logic                    task_end;

    entry_t stim [n_tests];
    int     errors;
    int     checks;
    int     tests_run;
    bit     aborted;

    paillier_top #(
        .word_w (word_w)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .task_req  (task_req),
        .task_cmd  (task_cmd),
        .a_data    (a_data),
        .a_valid   (a_valid),
        .b_data    (b_data),
        .b_valid   (b_valid),
        .out_data  (out_data),
        .out_valid (out_valid),
        .task_end  (task_end)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string what, input paillier_pkg::operand_t got,
                               input paillier_pkg::operand_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic paillier_pkg::operand_t random_operand(input paillier_pkg::operand_t lim);
        paillier_pkg::operand_t v;
        v = {$urandom, $urandom};
        return v % lim;
    endfunction

    function automatic paillier_pkg::operand_t expected_result(input paillier_pkg::task_cmd_e cmd,
                                                               input paillier_pkg::operand_t a,
                                                               input paillier_pkg::operand_t b);
        case (cmd)
            paillier_pkg::cmd_encrypt:  return encrypt_ref(a, b);
            paillier_pkg::cmd_homo_add: return mul_mod_ref(a, b);
            default:                    return exp_mod_ref(a, b);
        endcase
    endfunction

    // Fixed and random cases with uneven word gaps on a and b
    task automatic fill_table();
        stim[0] = '{paillier_pkg::cmd_homo_add, 64'h0123_4567_89ab_cdef,
                    64'h0fed_cba9_8765_4321, 0, 0, 1'b0};
        stim[1] = '{paillier_pkg::cmd_homo_add, '0, '0, 1, 3, 1'b1};
        stim[2] = '{paillier_pkg::cmd_scalar_mul, 64'h0000_0000_dead_beef, '0, 0, 0, 1'b0};
        stim[3] = '{paillier_pkg::cmd_scalar_mul, 64'h0abc_def0_1234_5679,
                    64'hfffe_ffff_7fff_ffff, 0, 2, 1'b0};
        stim[4] = '{paillier_pkg::cmd_scalar_mul, '0, '0, 2, 0, 1'b1};
        stim[5] = '{paillier_pkg::cmd_encrypt, 64'h0000_0000_0000_002a,
                    64'h0000_0001_2345_6789, 0, 0, 1'b0};
        stim[6] = '{paillier_pkg::cmd_encrypt, '0, '0, 0, 2, 1'b1};
        stim[7] = '{paillier_pkg::cmd_encrypt, '0, '0, 3, 1, 1'b1};
        stim[8] = '{paillier_pkg::cmd_decrypt, 64'h1111_2222_3333_4444,
                    64'h5555_6666_7777_8888, 0, 0, 1'b0};
        stim[9] = '{paillier_pkg::cmd_homo_add, '0, '0, 1, 0, 1'b1};
    endtask

    // Each stream advances on its own with its own idle gap
    task automatic send_operands(input paillier_pkg::operand_t a, input paillier_pkg::operand_t b,
                                 input int a_gap, input int b_gap);
        int ai;
        int bi;
        int a_wait;
        int b_wait;
        ai = 0;
        bi = 0;
        a_wait = 0;
        b_wait = 0;
        while (ai < n_words || bi < n_words) begin
            a_valid = 1'b0;
            b_valid = 1'b0;
            if (ai < n_words && a_wait == 0) begin
                a_data  = a[ai*word_w +: word_w];
                a_valid = 1'b1;
                ai++;
                a_wait  = a_gap;
            end else if (a_wait > 0) begin
                a_wait--;
            end
            if (bi < n_words && b_wait == 0) begin
                b_data  = b[bi*word_w +: word_w];
                b_valid = 1'b1;
                bi++;
                b_wait  = b_gap;
            end else if (b_wait > 0) begin
                b_wait--;
            end
            @(negedge clk);
        end
        a_valid = 1'b0;
        b_valid = 1'b0;
    endtask

    task automatic run_test(input int idx);
        entry_t                 e;
        paillier_pkg::operand_t got;
        int                     err_before;
        int                     waited;
        int                     words;
        int                     end_count;
        int                     end_idx;
        e = stim[idx];
        err_before = errors;
        if (e.rand_ops) begin
            e.b = random_operand(paillier_pkg::paillier_nsq);
            if (e.cmd == paillier_pkg::cmd_encrypt) begin
                e.a = random_operand(paillier_pkg::operand_t'(paillier_pkg::paillier_n));
            end else begin
                e.a = random_operand(paillier_pkg::paillier_nsq);
            end
        end
        // Let the controller settle back to idle after the last burst
        repeat (3) @(negedge clk);
        task_req = 1'b1;
        task_cmd = e.cmd;
        @(negedge clk);
        task_req = 1'b0;
        send_operands(e.a, e.b, e.a_gap, e.b_gap);
        if (e.cmd == paillier_pkg::cmd_decrypt) begin
            waited = 0;
            while (out_valid !== 1'b1 && waited < quiet_wait) begin
                @(negedge clk);
                waited++;
            end
            if (out_valid === 1'b1) begin
                errors++;
                $display("Output appeared after an ignored request in test %0d", idx);
            end
        end else begin
            waited = 0;
            while (out_valid !== 1'b1 && waited < out_timeout) begin
                @(negedge clk);
                waited++;
            end
            if (out_valid !== 1'b1) begin
                errors++;
                aborted = 1'b1;
                $display("Timed out waiting for the output words of test %0d", idx);
            end else begin
                got       = '0;
                words     = 0;
                end_count = 0;
                end_idx   = -1;
                while (out_valid === 1'b1 && words < n_words + 2) begin
                    if (words < n_words) begin
                        got[words*word_w +: word_w] = out_data;
                    end
                    if (task_end === 1'b1) begin
                        end_count++;
                        end_idx = words;
                    end
                    words++;
                    @(negedge clk);
                end
                check_count("output word count", words, n_words);
                check_count("task_end pulses", end_count, 1);
                check_count("task_end word index", end_idx, n_words - 1);
                check_value("result", got, expected_result(e.cmd, e.a, e.b));
            end
        end
        tests_run++;
        $display("test %0d %s: %s", idx, e.cmd.name(), (errors == err_before) ? "ok" : "bad");
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        task_req  = 1'b0;
        task_cmd  = paillier_pkg::cmd_encrypt;
        a_data    = '0;
        a_valid   = 1'b0;
        b_data    = '0;
        b_valid   = 1'b0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        aborted   = 1'b0;
        void'($urandom(32'h0d08_7eba));
        fill_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            if (!aborted) begin
                run_test(i);
            end
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* hdl/paillier_top.sv */
module paillier_top #(
    parameter int word_w = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    task_req,
    input  paillier_pkg::task_cmd_e task_cmd,
    input  logic [word_w-1:0]       a_data,
    input  logic                    a_valid,
    input  logic [word_w-1:0]       b_data,
    input  logic                    b_valid,
    output logic [word_w-1:0]       out_data,
    output logic                    out_valid,
    output logic                    task_end
);

    logic                   clear;
    logic                   loaded;
    logic                   send;
    logic                   busy;
    paillier_pkg::operand_t a_op;
    paillier_pkg::operand_t b_op;
    paillier_pkg::operand_t final_value;

    mod_op_if mul_bus ();
    mod_op_if exp_bus ();

    operand_loader #(
        .word_w (word_w)
    ) u_loader (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (clear),
        .a_data  (a_data),
        .a_valid (a_valid),
        .b_data  (b_data),
        .b_valid (b_valid),
        .loaded  (loaded),
        .a_op    (a_op),
        .b_op    (b_op)
    );

    paillier_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .task_req    (task_req),
        .task_cmd    (task_cmd),
        .clear       (clear),
        .loaded      (loaded),
        .a_op        (a_op),
        .b_op        (b_op),
        .mul         (mul_bus.ctrl),
        .exp         (exp_bus.ctrl),
        .send        (send),
        .final_value (final_value),
        .busy        (busy)
    );

    mod_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (mul_bus.core)
    );

    mod_exp u_exp (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (exp_bus.core)
    );

    result_streamer #(
        .word_w (word_w)
    ) u_streamer (
        .clk       (clk),
        .rst_n     (rst_n),
        .send      (send),
        .value     (final_value),
        .out_data  (out_data),
        .out_valid (out_valid),
        .task_end  (task_end),
        .busy      (busy)
    );

endmodule

/* hdl/paillier_ctrl.sv */
module paillier_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    task_req,
    input  paillier_pkg::task_cmd_e task_cmd,
    output logic                    clear,
    input  logic                    loaded,
    input  paillier_pkg::operand_t  a_op,
    input  paillier_pkg::operand_t  b_op,
    mod_op_if.ctrl                  mul,
    mod_op_if.ctrl                  exp,
    output logic                    send,
    output paillier_pkg::operand_t  final_value,
    input  logic                    busy
);

    localparam paillier_pkg::operand_t n_ext = paillier_pkg::operand_t'(paillier_pkg::paillier_n);

    paillier_pkg::ctrl_state_e state;
    paillier_pkg::task_cmd_e   cmd_r;
    logic                      mul_seen;
    logic                      exp_seen;
    logic                      both_seen;
    logic                      use_exp;

    // Loader only collects words while waiting for operands
    assign clear = (state != paillier_pkg::st_load);

    assign both_seen = (mul_seen || mul.done) && (exp_seen || exp.done);

    // Scalar multiplication is the only task that ends on the exponentiation core
    assign use_exp     = (state == paillier_pkg::st_single) &&
                         (cmd_r == paillier_pkg::cmd_scalar_mul);
    assign final_value = use_exp ? exp.result : mul.result;
    assign send        = ((state == paillier_pkg::st_enc_final) && mul.done) ||
                         ((state == paillier_pkg::st_single) && (use_exp ? exp.done : mul.done));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= paillier_pkg::st_idle;
            cmd_r     <= paillier_pkg::cmd_encrypt;
            mul.start <= 1'b0;
            exp.start <= 1'b0;
            mul_seen  <= 1'b0;
            exp_seen  <= 1'b0;
        end else begin
            mul.start <= 1'b0;
            exp.start <= 1'b0;
            case (state)
                paillier_pkg::st_idle: begin
                    if (task_req && (task_cmd != paillier_pkg::cmd_decrypt)) begin
                        cmd_r <= task_cmd;
                        state <= paillier_pkg::st_load;
                    end
                end
                paillier_pkg::st_load: begin
                    if (loaded) begin
                        mul_seen <= 1'b0;
                        exp_seen <= 1'b0;
                        case (cmd_r)
                            paillier_pkg::cmd_encrypt: begin
                                mul.start <= 1'b1;
                                exp.start <= 1'b1;
                                state     <= paillier_pkg::st_enc_first;
                            end
                            paillier_pkg::cmd_homo_add: begin
                                mul.start <= 1'b1;
                                state     <= paillier_pkg::st_single;
                            end
                            default: begin
                                exp.start <= 1'b1;
                                state     <= paillier_pkg::st_single;
                            end
                        endcase
                    end
                end
                paillier_pkg::st_enc_first: begin
                    mul_seen <= mul_seen || mul.done;
                    exp_seen <= exp_seen || exp.done;
                    if (both_seen) begin
                        mul.start <= 1'b1;
                        state     <= paillier_pkg::st_enc_final;
                    end
                end
                paillier_pkg::st_enc_final, paillier_pkg::st_single: begin
                    if (send) begin
                        state <= paillier_pkg::st_output;
                    end
                end
                paillier_pkg::st_output: begin
                    if (!busy) begin
                        state <= paillier_pkg::st_idle;
                    end
                end
                default: state <= paillier_pkg::st_idle;
            endcase
        end
    end

    // Core operands, only meaningful together with a start
    always_ff @(posedge clk) begin
        if ((state == paillier_pkg::st_load) && loaded) begin
            if (cmd_r == paillier_pkg::cmd_encrypt) begin
                mul.x <= a_op;
                mul.y <= n_ext;
                exp.x <= b_op;
                exp.y <= n_ext;
            end else begin
                mul.x <= a_op;
                mul.y <= b_op;
                exp.x <= a_op;
                exp.y <= b_op;
            end
        end else if ((state == paillier_pkg::st_enc_first) && both_seen) begin
            // m*n < n*n, so adding one needs no reduction
            mul.x <= mul.result + 1'b1;
            mul.y <= exp.result;
        end
    end

endmodule

/* hdl/result_streamer.sv */
module result_streamer #(
    parameter int word_w = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   send,
    input  paillier_pkg::operand_t value,
    output logic [word_w-1:0]      out_data,
    output logic                   out_valid,
    output logic                   task_end,
    output logic                   busy
);

    localparam int n_words = paillier_pkg::operand_w / word_w;
    localparam int cnt_w   = $clog2(n_words + 1);

    logic [cnt_w-1:0]       cnt;
    paillier_pkg::operand_t shreg;

    // Words still to go out, zero when idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (send) begin
            cnt <= cnt_w'(n_words);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            shreg <= value;
        end else if (cnt != '0) begin
            shreg <= shreg >> word_w;
        end
    end

    assign out_valid = (cnt != '0);
    assign out_data  = out_valid ? shreg[word_w-1:0] : '0;
    assign task_end  = (cnt == cnt_w'(1));
    assign busy      = out_valid;

endmodule

/* hdl/operand_loader.sv */
module operand_loader #(
    parameter int word_w = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic [word_w-1:0]      a_data,
    input  logic                   a_valid,
    input  logic [word_w-1:0]      b_data,
    input  logic                   b_valid,
    output logic                   loaded,
    output paillier_pkg::operand_t a_op,
    output paillier_pkg::operand_t b_op
);

    localparam int n_words = paillier_pkg::operand_w / word_w;
    localparam int cnt_w   = $clog2(n_words + 1);

    logic [cnt_w-1:0] a_cnt;
    logic [cnt_w-1:0] b_cnt;
    logic             a_take;
    logic             b_take;
    logic             both_full;
    logic             both_full_nxt;

    // Counters saturate at the full count, later words are dropped
    assign a_take = a_valid && (a_cnt != cnt_w'(n_words));
    assign b_take = b_valid && (b_cnt != cnt_w'(n_words));

    assign both_full     = (a_cnt == cnt_w'(n_words)) && (b_cnt == cnt_w'(n_words));
    assign both_full_nxt = ((a_cnt + cnt_w'(a_take)) == cnt_w'(n_words)) &&
                           ((b_cnt + cnt_w'(b_take)) == cnt_w'(n_words));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_cnt  <= '0;
            b_cnt  <= '0;
            loaded <= 1'b0;
        end else begin
            loaded <= !clear && both_full_nxt && !both_full;
            if (clear) begin
                a_cnt <= '0;
                b_cnt <= '0;
            end else begin
                a_cnt <= a_cnt + cnt_w'(a_take);
                b_cnt <= b_cnt + cnt_w'(b_take);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!clear && a_take) begin
            a_op[a_cnt*word_w +: word_w] <= a_data;
        end
        if (!clear && b_take) begin
            b_op[b_cnt*word_w +: word_w] <= b_data;
        end
    end

endmodule

/* hdl/mod_exp.sv */
module mod_exp (
    input  logic    clk,
    input  logic    rst_n,
    mod_op_if.core  op
);

    localparam int cnt_w = $clog2(paillier_pkg::operand_w);

    typedef enum logic [2:0] {
        ex_idle,
        ex_square,
        ex_sq_wait,
        ex_mult,
        ex_mul_wait
    } exp_state_e;

    exp_state_e             state;
    logic [cnt_w-1:0]       cnt;
    logic                   done_q;
    paillier_pkg::operand_t base;
    paillier_pkg::operand_t expo;
    paillier_pkg::operand_t acc;
    logic                   cur_bit;
    logic                   step_done;

    // Private multiplier, squares and multiplies in turn
    mod_op_if inner ();

    mod_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (inner.core)
    );

    assign inner.start = (state == ex_square) || (state == ex_mult);
    assign inner.x     = acc;
    assign inner.y     = (state == ex_mult) ? base : acc;

    assign cur_bit = expo[cnt];

    // Current exponent bit fully handled
    assign step_done = inner.done &&
                       (((state == ex_sq_wait) && !cur_bit) || (state == ex_mul_wait));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ex_idle;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (step_done) begin
                if (cnt == '0) begin
                    done_q <= 1'b1;
                    state  <= ex_idle;
                end else begin
                    cnt   <= cnt - 1'b1;
                    state <= ex_square;
                end
            end else begin
                case (state)
                    ex_idle: begin
                        if (op.start) begin
                            cnt   <= cnt_w'(paillier_pkg::operand_w - 1);
                            state <= ex_square;
                        end
                    end
                    ex_square:   state <= ex_sq_wait;
                    ex_sq_wait: begin
                        // Only reached with bit set, else step_done took over
                        if (inner.done) begin
                            state <= ex_mult;
                        end
                    end
                    ex_mult:     state <= ex_mul_wait;
                    default:     state <= state;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ex_idle) && op.start) begin
            base <= op.x;
            expo <= op.y;
            acc  <= paillier_pkg::operand_t'(1);
        end else if (inner.done) begin
            acc <= inner.result;
        end
    end

    assign op.done   = done_q;
    assign op.result = acc;

endmodule

/* hdl/mod_mul.sv */
module mod_mul (
    input  logic    clk,
    input  logic    rst_n,
    mod_op_if.core  op
);

    localparam int cnt_w = $clog2(paillier_pkg::operand_w + 1);
    localparam logic [paillier_pkg::operand_w+1:0] mod_ext = {2'b00, paillier_pkg::paillier_nsq};

    logic                   busy;
    logic [cnt_w-1:0]       cnt;
    logic                   done_q;
    paillier_pkg::operand_t xr;
    paillier_pkg::operand_t yr;
    paillier_pkg::operand_t acc;

    logic [paillier_pkg::operand_w+1:0] sum;
    logic [paillier_pkg::operand_w+1:0] red1;
    logic [paillier_pkg::operand_w+1:0] red2;

    // One interleaved step: 2*acc + bit*x stays below 3*nsq
    always_comb begin
        sum  = {1'b0, acc, 1'b0} + (yr[paillier_pkg::operand_w-1] ? {2'b00, xr} : '0);
        red1 = (sum >= mod_ext) ? sum - mod_ext : sum;
        red2 = (red1 >= mod_ext) ? red1 - mod_ext : red1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (op.start) begin
                busy <= 1'b1;
                cnt  <= cnt_w'(paillier_pkg::operand_w);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                // Last bit of y processed on this edge
                if (cnt == cnt_w'(1)) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.start) begin
            xr  <= op.x;
            yr  <= op.y;
            acc <= '0;
        end else if (busy) begin
            acc <= red2[paillier_pkg::operand_w-1:0];
            yr  <= yr << 1;
        end
    end

    assign op.done   = done_q;
    assign op.result = acc;

endmodule

/* hdl/mod_op_if.sv */
interface mod_op_if;

    // Request side, sampled by the core on start
    logic                   start;
    paillier_pkg::operand_t x;
    paillier_pkg::operand_t y;

    // Completion side, result is stable from done until the next start
    logic                   done;
    paillier_pkg::operand_t result;

    modport ctrl (
        output start, x, y,
        input  done, result
    );

    modport core (
        input  start, x, y,
        output done, result
    );

endinterface

/* hdl/paillier_pkg.sv */
package paillier_pkg;

    // Width of every operand, result and modulus
    localparam int operand_w = 64;

    typedef logic [operand_w-1:0] operand_t;

    // Public key n, odd and half the operand width
    localparam logic [operand_w/2-1:0] paillier_n = 32'hd3a5_c17b;

    // Modulus of both arithmetic cores
    localparam operand_t paillier_nsq = operand_t'(paillier_n) * operand_t'(paillier_n);

    // Command codes keep the reference encoding
    typedef enum logic [1:0] {
        cmd_encrypt    = 2'b00,
        cmd_decrypt    = 2'b01,
        cmd_homo_add   = 2'b10,
        cmd_scalar_mul = 2'b11
    } task_cmd_e;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_enc_first,
        st_enc_final,
        st_single,
        st_output
    } ctrl_state_e;

endpackage
